//--- dv/tb_ascon_perm.sv
/* testbench for the masked ASCON permutation engine; random states and round counts
   run through the DUT and are checked against an unmasked reference model */
`timescale 1ns/1ps

module tb_ascon_perm import ascon_pkg::*; ();

    logic                   clk;
    logic                   reset_n_lfsr;
    logic                   i_start;
    logic [ROUND_WIDTH-1:0] i_rounds;
    logic [STATE_WIDTH-1:0] i_state;
    logic [STATE_WIDTH-1:0] o_state;
    logic                   o_busy;
    logic                   o_done;
    integer                 seed;
    int                     errors;
    int                     tests_ok;
    int                     tests_bad;

    tb_clock u_clock (.o_clk(clk));

    ascon_perm_top DUT (.*);

    function automatic logic [WORD_WIDTH-1:0] rotate_right(
        input logic [WORD_WIDTH-1:0] x,
        input int                    n
    );
        logic [2*WORD_WIDTH-1:0] both;
        both = {x, x} >> n;  // low word is the rotated row
        return both[WORD_WIDTH-1:0];
    endfunction

    // plain ascon rounds: constant, affine, chi, affine, diffusion
    function automatic logic [STATE_WIDTH-1:0] model_perm(
        input logic [STATE_WIDTH-1:0] s_in,
        input int                     rounds
    );
        logic [WORD_WIDTH-1:0]  x [0:ROW_COUNT-1];
        logic [WORD_WIDTH-1:0]  t [0:ROW_COUNT-1];
        logic [STATE_WIDTH-1:0] s_out;
        for (int k = 0; k < ROW_COUNT; k++) x[k] = s_in[WORD_WIDTH*k +: WORD_WIDTH];
        for (int r = MAX_ROUNDS - rounds; r < MAX_ROUNDS; r++) begin
            x[2][7:0] = x[2][7:0] ^ (RC_BASE - 8'(r) * RC_STEP);
            x[0] = x[0] ^ x[4];
            x[4] = x[4] ^ x[3];
            x[2] = x[2] ^ x[1];
            for (int k = 0; k < ROW_COUNT; k++) begin
                t[k] = x[k] ^ (~x[(k + 1) % ROW_COUNT] & x[(k + 2) % ROW_COUNT]);  // chi
            end
            x[1] = t[1] ^ t[0];
            x[0] = t[0] ^ t[4];
            x[3] = t[3] ^ t[2];
            x[2] = ~t[2];
            x[4] = t[4];
            for (int k = 0; k < ROW_COUNT; k++) begin
                x[k] = x[k] ^ rotate_right(x[k], ROT_A[k]) ^ rotate_right(x[k], ROT_B[k]);
            end
        end
        for (int k = 0; k < ROW_COUNT; k++) s_out[WORD_WIDTH*k +: WORD_WIDTH] = x[k];
        return s_out;
    endfunction

    task automatic check_value(
        input string                  name,
        input logic [STATE_WIDTH-1:0] got,
        input logic [STATE_WIDTH-1:0] exp
    );
        if (got !== exp) begin
            $display("FAILED %s: got %0h, expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic random_state(output logic [STATE_WIDTH-1:0] s);
        for (int k = 0; k < STATE_WIDTH / 32; k++) s[32*k +: 32] = $random(seed);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;  // drive and sample just after the edge
    endtask

    // one permutation; a nonzero intruder is started mid-run and must be ignored
    task automatic run_perm(
        input  logic [STATE_WIDTH-1:0] st,
        input  int                     rounds,
        input  logic [STATE_WIDTH-1:0] intruder,
        output logic [STATE_WIDTH-1:0] result
    );
        int cycles;
        cycles = 0;
        while (o_busy && cycles < 100) begin
            next_cycle();
            cycles++;
        end
        if (o_busy) begin
            $display("timeout: DUT still busy 100 cycles before a new start");
            errors++;
        end
        i_state  = st;
        i_rounds = ROUND_WIDTH'(rounds);
        i_start  = 1'b1;
        next_cycle();  // edge 0 takes the start
        i_start = 1'b0;
        check_value("o_busy", o_busy, 1);
        cycles = 0;
        while (!o_done && cycles < 100) begin
            next_cycle();
            cycles++;
            i_start = (cycles == 4) && (intruder != '0);
            if (i_start) i_state = intruder;
        end
        i_start = 1'b0;
        if (!o_done) begin
            $display("timeout: o_done did not rise within 100 cycles of start");
            errors++;
        end
        check_value("done_latency", cycles, 3 * rounds);  // three cycles per round
        check_value("o_busy", o_busy, 0);
        result = o_state;
        next_cycle();
        check_value("o_done", o_done, 0);         // pulse lasts one cycle
        check_value("o_state", o_state, result);  // result held after done
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        logic [STATE_WIDTH-1:0] st;
        logic [STATE_WIDTH-1:0] other;
        logic [STATE_WIDTH-1:0] res;
        logic [STATE_WIDTH-1:0] res2;
        int                     rounds;
        int                     mark;
        bit                     seen_busy;
        bit                     seen_done;
        seed         = 32'hfc99bf79;
        errors       = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        reset_n_lfsr = 1'b0;
        i_start      = 1'b0;
        i_rounds     = '0;
        i_state      = '0;
        repeat (8) @(posedge clk);
        #1 reset_n_lfsr = 1'b1;

        mark = errors;
        check_value("o_busy", o_busy, 0);
        check_value("o_done", o_done, 0);
        finish_test("reset", mark);

        mark = errors;
        repeat (20) begin
            random_state(st);
            run_perm(st, MAX_ROUNDS, '0, res);
            check_value("o_state", res, model_perm(st, MAX_ROUNDS));
        end
        finish_test("full_rounds", mark);

        mark = errors;
        repeat (30) begin
            random_state(st);
            rounds = $unsigned($random(seed)) % MAX_ROUNDS + 1;
            run_perm(st, rounds, '0, res);
            check_value("o_state", res, model_perm(st, rounds));
        end
        finish_test("random_rounds", mark);

        mark = errors;
        random_state(st);
        run_perm(st, MAX_ROUNDS, '0, res);
        run_perm(st, MAX_ROUNDS, '0, res2);  // prng has moved on, other masks
        check_value("o_state_repeat", res2, res);
        check_value("o_state", res, model_perm(st, MAX_ROUNDS));
        finish_test("mask_independence", mark);

        mark = errors;
        random_state(st);
        random_state(other);
        run_perm(st, MAX_ROUNDS, other, res);
        check_value("o_state", res, model_perm(st, MAX_ROUNDS));
        finish_test("start_while_busy", mark);

        mark = errors;
        for (int k = 0; k < 4; k++) begin
            seen_busy = 1'b0;
            seen_done = 1'b0;
            random_state(i_state);
            i_rounds = (k == 0) ? '0 : ROUND_WIDTH'(12 + k);  // 0, 13, 14, 15
            i_start  = 1'b1;
            next_cycle();
            i_start = 1'b0;
            repeat (50) begin
                seen_busy |= o_busy;
                seen_done |= o_done;
                next_cycle();
            end
            check_value("o_busy", seen_busy, 0);
            check_value("o_done", seen_done, 0);
            check_value("o_state", o_state, res);  // rejected start keeps the last result
        end
        finish_test("bad_round_count", mark);

        $display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock.sv
/* free-running testbench clock, 100 ns period */
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;  // half period
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the ascon permutation testbench with verilator, runs it and checks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f sources.f \
    --top-module tb_ascon_perm -o sim_ascon_perm

output="$(./obj_dir/sim_ascon_perm)"
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"; then
    exit 0
fi
exit 1

//--- source/ascon_perm_top.sv
/* top of the masked ASCON permutation engine; load a state with a round count,
   the last R rounds run at three cycles each and the result shows with o_done */
`timescale 1ns/1ps

module ascon_perm_top import ascon_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n_lfsr,
    input  logic                   i_start,
    input  logic [ROUND_WIDTH-1:0] i_rounds,
    input  logic [STATE_WIDTH-1:0] i_state,
    output logic [STATE_WIDTH-1:0] o_state,
    output logic                   o_busy,
    output logic                   o_done
);

    ascon_state_u           in_state;
    ascon_state_u           round_state;
    ascon_state_u           next_state;
    ascon_state_u           mask_rows;
    ascon_state_u           fresh_rows;
    logic [ROUND_WIDTH-1:0] round_idx;
    logic                   round_go;
    logic                   next_valid;

    stage_if stg1 ();  // sbox input -> DOM sbox
    stage_if stg2 ();  // DOM sbox -> linear output

    assign in_state.flat = i_state;
    assign o_state       = round_state.flat;  // held after done

    mask_prng u_prng (
        .clk          (clk),
        .reset_n_lfsr (reset_n_lfsr),
        .o_mask_rows  (mask_rows),
        .o_fresh_rows (fresh_rows)
    );

    perm_control u_ctrl (
        .clk           (clk),
        .reset_n_lfsr  (reset_n_lfsr),
        .i_start       (i_start),
        .i_rounds      (i_rounds),
        .i_state       (in_state),
        .i_next_state  (next_state),
        .i_next_valid  (next_valid),
        .o_round_state (round_state),
        .o_round_idx   (round_idx),
        .o_round_go    (round_go),
        .o_busy        (o_busy),
        .o_done        (o_done)
    );

    sbox_input_stage u_sbox_in (
        .clk           (clk),
        .reset_n_lfsr  (reset_n_lfsr),
        .i_round_state (round_state),
        .i_round_idx   (round_idx),
        .i_round_go    (round_go),
        .i_mask_rows   (mask_rows),
        .o_stg         (stg1.producer)
    );

    dom_sbox_stage u_dom_sbox (
        .clk          (clk),
        .reset_n_lfsr (reset_n_lfsr),
        .i_fresh_rows (fresh_rows),
        .i_stg        (stg1.consumer),
        .o_stg        (stg2.producer)
    );

    linear_output_stage u_lin_out (
        .i_stg        (stg2.consumer),
        .o_next_state (next_state),
        .o_next_valid (next_valid)
    );

endmodule

//--- source/ascon_pkg.sv
/* shared widths, round schedule, rotation and PRNG constants and the state union
   for the masked ASCON permutation engine; imported by every RTL file */
package ascon_pkg;

    localparam int WORD_WIDTH  = 64;                      // one state row
    localparam int ROW_COUNT   = 5;                       // rows x0..x4
    localparam int STATE_WIDTH = ROW_COUNT * WORD_WIDTH;  // 320 bit state
    localparam int MAX_ROUNDS  = 12;                      // full schedule length
    localparam int ROUND_WIDTH = 4;                       // round count and index width

    // round constant of index i is RC_BASE - i*RC_STEP, xored into low byte of x2
    localparam logic [7:0] RC_BASE = 8'hF0;
    localparam logic [7:0] RC_STEP = 8'h0F;

    // linear diffusion, right rotations per row
    localparam int ROT_A [0:ROW_COUNT-1] = '{19, 61, 1, 10, 7};
    localparam int ROT_B [0:ROW_COUNT-1] = '{28, 39, 6, 17, 41};

    // mask PRNG
    localparam int LFSR_WIDTH = 64;
    localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 64'h5A3C_96E1_0F7B_2D48; // any nonzero value
    localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 64'hD800_0000_0000_0000; // x^64+x^63+x^61+x^60+1

    // the single prng word is widened into rows by these rotations
    localparam int MASK_ROT  [0:ROW_COUNT-1] = '{3, 17, 29, 44, 58};
    localparam int FRESH_ROT [0:ROW_COUNT-1] = '{9, 23, 36, 50, 61};

    // one 320 bit state, seen flat or as five rows (x0 in the low word)
    typedef union packed {
        logic [STATE_WIDTH-1:0]               flat;
        logic [ROW_COUNT-1:0][WORD_WIDTH-1:0] rows;
    } ascon_state_u;

    // right rotation of one row
    function automatic logic [WORD_WIDTH-1:0] rotr(
        input logic [WORD_WIDTH-1:0] x,
        input int unsigned           n
    );
        return (x >> n) | (x << (WORD_WIDTH - n));
    endfunction

endpackage

//--- source/dom_sbox_stage.sv
/* second pipeline stage: masked chi step, first order DOM AND per row with
   fresh randomness on the cross-domain terms, registered into stg2 */
`timescale 1ns/1ps

module dom_sbox_stage import ascon_pkg::*; (
    input  logic         clk,
    input  logic         reset_n_lfsr,
    input  ascon_state_u i_fresh_rows,
    stage_if.consumer    i_stg,
    stage_if.producer    o_stg
);

    // one output share of x_i ^ (~x_{i+1} & x_{i+2})
    // own-domain product kept, cross product re-masked with the fresh row;
    // the same fresh row goes into both shares and cancels on recombination
    function automatic ascon_state_u dom_chi(
        input ascon_state_u own,
        input ascon_state_u other,
        input ascon_state_u fresh,
        input logic         invert   // complement lives in share a only
    );
        ascon_state_u          r;
        logic [WORD_WIDTH-1:0] nx;
        for (int i = 0; i < ROW_COUNT; i++) begin
            nx = invert ? ~own.rows[(i + 1) % ROW_COUNT] : own.rows[(i + 1) % ROW_COUNT];
            r.rows[i] = own.rows[i]
                        ^ (nx & own.rows[(i + 2) % ROW_COUNT])                      // inner domain
                        ^ ((nx & other.rows[(i + 2) % ROW_COUNT]) ^ fresh.rows[i]); // cross domain
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge reset_n_lfsr) begin
        if (!reset_n_lfsr) begin
            o_stg.valid <= 1'b0;
        end else begin
            o_stg.valid <= i_stg.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_stg.valid) begin
            o_stg.share_a <= dom_chi(i_stg.share_a, i_stg.share_b, i_fresh_rows, 1'b1);
            o_stg.share_b <= dom_chi(i_stg.share_b, i_stg.share_a, i_fresh_rows, 1'b0);
        end
    end

endmodule

//--- source/linear_output_stage.sv
/* last stage, combinational: second affine layer per share, recombination
   and the linear diffusion layer; result goes back to the state register */
`timescale 1ns/1ps

module linear_output_stage import ascon_pkg::*; (
    stage_if.consumer    i_stg,
    output ascon_state_u o_next_state,
    output logic         o_next_valid
);

    ascon_state_u plain;

    // x1 ^= x0, x0 ^= x4, x3 ^= x2, then x2 inverted (one share only)
    function automatic ascon_state_u affine_out(input ascon_state_u s, input logic invert);
        ascon_state_u r;
        r         = s;
        r.rows[1] = s.rows[1] ^ s.rows[0];
        r.rows[0] = s.rows[0] ^ s.rows[4];
        r.rows[3] = s.rows[3] ^ s.rows[2];  // uses x2 before the inversion
        r.rows[2] = invert ? ~s.rows[2] : s.rows[2];
        return r;
    endfunction

    assign plain = affine_out(i_stg.share_a, 1'b1) ^ affine_out(i_stg.share_b, 1'b0);

    always_comb begin
        for (int i = 0; i < ROW_COUNT; i++) begin
            o_next_state.rows[i] = plain.rows[i]
                                   ^ rotr(plain.rows[i], ROT_A[i])
                                   ^ rotr(plain.rows[i], ROT_B[i]);
        end
    end

    assign o_next_valid = i_stg.valid;  // store strobe for the control

endmodule

//--- source/mask_prng.sv
/* free-running 64 bit galois LFSR; its word is rotated into share masks
   and fresh DOM randomness, both changing every cycle */
`timescale 1ns/1ps

module mask_prng import ascon_pkg::*; (
    input  logic         clk,
    input  logic         reset_n_lfsr,
    output ascon_state_u o_mask_rows,   // to share split
    output ascon_state_u o_fresh_rows   // to DOM re-masking
);

    logic [LFSR_WIDTH-1:0] lfsr_q;

    // shift right, fold taps back in when the low bit drops out
    always_ff @(posedge clk or negedge reset_n_lfsr) begin
        if (!reset_n_lfsr) begin
            lfsr_q <= LFSR_SEED;
        end else begin
            lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : '0);
        end
    end

    always_comb begin
        for (int i = 0; i < ROW_COUNT; i++) begin
            o_mask_rows.rows[i]  = rotr(lfsr_q, MASK_ROT[i]);
            o_fresh_rows.rows[i] = rotr(lfsr_q, FRESH_ROT[i]);  // different rotation per row
        end
    end

endmodule

//--- source/perm_control.sv
/* round loop control: unmasked state register, round index and busy/done;
   issues one go pulse per round and takes the stage result three cycles later */
`timescale 1ns/1ps

module perm_control import ascon_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n_lfsr,
    input  logic                   i_start,
    input  logic [ROUND_WIDTH-1:0] i_rounds,      // 1..MAX_ROUNDS accepted
    input  ascon_state_u           i_state,
    input  ascon_state_u           i_next_state,  // result of current round
    input  logic                   i_next_valid,
    output ascon_state_u           o_round_state,
    output logic [ROUND_WIDTH-1:0] o_round_idx,
    output logic                   o_round_go,
    output logic                   o_busy,
    output logic                   o_done
);

    ascon_state_u           state_q;
    logic [ROUND_WIDTH-1:0] idx_q;
    logic                   busy_q;
    logic                   done_q;
    logic                   go_q;
    logic                   start_ok;
    logic                   last_round;

    // start only when idle and the count is in range
    assign start_ok = i_start && !busy_q && (i_rounds != '0)
                      && (i_rounds <= ROUND_WIDTH'(MAX_ROUNDS));
    assign last_round = (idx_q == ROUND_WIDTH'(MAX_ROUNDS - 1));

    always_ff @(posedge clk or negedge reset_n_lfsr) begin
        if (!reset_n_lfsr) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            go_q   <= 1'b0;
            idx_q  <= '0;
        end else begin
            done_q <= 1'b0;  // pulses by default
            go_q   <= 1'b0;
            if (start_ok) begin
                busy_q <= 1'b1;
                idx_q  <= ROUND_WIDTH'(MAX_ROUNDS) - i_rounds;  // run the last R rounds
                go_q   <= 1'b1;
            end else if (i_next_valid) begin
                if (last_round) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    idx_q <= idx_q + 1'b1;
                    go_q  <= 1'b1;  // next round starts right away
                end
            end
        end
    end

    // next_valid only arrives while busy, so never together with a start
    always_ff @(posedge clk) begin
        if (start_ok) begin
            state_q <= i_state;
        end else if (i_next_valid) begin
            state_q <= i_next_state;
        end
    end

    assign o_round_state = state_q;  // also the visible result once done
    assign o_round_idx   = idx_q;
    assign o_round_go    = go_q;
    assign o_busy        = busy_q;
    assign o_done        = done_q;

endmodule

//--- source/sbox_input_stage.sv
/* first pipeline stage: round constant, split into two shares with PRNG masks,
   first affine layer on each share, registered into stg1 */
`timescale 1ns/1ps

module sbox_input_stage import ascon_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n_lfsr,
    input  ascon_state_u           i_round_state,
    input  logic [ROUND_WIDTH-1:0] i_round_idx,
    input  logic                   i_round_go,
    input  ascon_state_u           i_mask_rows,
    stage_if.producer              o_stg
);

    logic [7:0]   round_const;
    ascon_state_u with_rc;
    ascon_state_u split_a;
    ascon_state_u split_b;

    // x0 ^= x4, x2 ^= x1, x4 ^= x3, applied per share
    function automatic ascon_state_u affine_in(input ascon_state_u s);
        ascon_state_u r;
        r         = s;
        r.rows[0] = s.rows[0] ^ s.rows[4];
        r.rows[2] = s.rows[2] ^ s.rows[1];
        r.rows[4] = s.rows[4] ^ s.rows[3];
        return r;
    endfunction

    assign round_const = RC_BASE - (RC_STEP * 8'(i_round_idx));

    always_comb begin
        with_rc               = i_round_state;
        with_rc.rows[2][7:0]  = i_round_state.rows[2][7:0] ^ round_const;  // constant into x2
        split_a.flat          = with_rc.flat ^ i_mask_rows.flat;            // masked data
        split_b               = i_mask_rows;                                // the mask itself
    end

    always_ff @(posedge clk or negedge reset_n_lfsr) begin
        if (!reset_n_lfsr) begin
            o_stg.valid <= 1'b0;
        end else begin
            o_stg.valid <= i_round_go;
        end
    end

    // register before the DOM ANDs so their inputs settle independently
    always_ff @(posedge clk) begin
        if (i_round_go) begin
            o_stg.share_a <= affine_in(split_a);
            o_stg.share_b <= affine_in(split_b);
        end
    end

endmodule

//--- source/stage_if.sv
/* link between two pipeline stages: both registered shares plus a valid flag */
`timescale 1ns/1ps

interface stage_if import ascon_pkg::*; ();

    ascon_state_u share_a;  // domain a
    ascon_state_u share_b;  // domain b
    logic         valid;    // one cycle per round

    modport producer (
        output share_a, share_b, valid
    );

    modport consumer (
        input share_a, share_b, valid
    );

endinterface

//--- sources.f
source/ascon_pkg.sv
source/stage_if.sv
source/mask_prng.sv
source/perm_control.sv
source/sbox_input_stage.sv
source/dom_sbox_stage.sv
source/linear_output_stage.sv
source/ascon_perm_top.sv
dv/tb_clock.sv
dv/tb_ascon_perm.sv
